/* all.f */
common/dcache_pkg.sv
common/dcache_biucmd_if.sv
common/dcache_mem_if.sv
verilog/dcache_req_pipe.sv
memory/dcache_memory.sv
verilog/dcache_hit_ctrl.sv
verilog/dcache_biu_ctrl.sv
verilog/dcache_core.sv
tests/tb_dcache.sv

/* common/dcache_biucmd_if.sv */
interface dcache_biucmd_if;
  import dcache_pkg::*;

  biucmd_t cmd;        // Held until ack
  adr_t    adr;
  word_t   d;          // Store data already on its lanes
  be_t     be;
  logic    ack;        // One cycle pulse
  logic    busy;
  logic    err;
  line_t   line;       // Filled line, valid with ack

  modport hit (
    output cmd, adr, d, be,
    input  ack, busy, err, line
  );

  modport biu (
    input  cmd, adr, d, be,
    output ack, busy, err, line
  );

endinterface

/* common/dcache_mem_if.sv */
interface dcache_mem_if #(
  parameter int WAYS = 2
);
  import dcache_pkg::*;

  // Lookup results in the tag stage
  logic            hit;
  logic [WAYS-1:0] ways_hit;
  line_t           rd_line;

  // Write side
  logic            we;         // Store word pulse
  logic            fill;       // Line fill pulse
  logic            inval;      // Invalidate all sets
  idx_t            wr_idx;
  offs_t           offs;
  word_t           d;
  be_t             be;
  logic [WAYS-1:0] wr_ways;    // Ways hit by the store
  line_t           fill_line;
  ctag_t           fill_tag;

  modport ctrl (
    input  hit, ways_hit, rd_line,
    output we, fill, inval, wr_idx, offs, d, be, wr_ways, fill_line, fill_tag
  );

  modport mem (
    output hit, ways_hit, rd_line,
    input  we, fill, inval, wr_idx, offs, d, be, wr_ways, fill_line, fill_tag
  );

endinterface

/* common/dcache_pkg.sv */
package dcache_pkg;

  // ----------------------------------------
  // Cache geometry
  // ----------------------------------------
  localparam int XLEN       = 32;
  localparam int PLEN       = 32;
  localparam int BLOCK_SIZE = 16;                        // Bytes per line
  localparam int BURST_SIZE = BLOCK_SIZE / (XLEN / 8);   // Words per line
  localparam int SETS       = 64;
  localparam int IDX_BITS   = $clog2(SETS);
  localparam int OFFS_BITS  = $clog2(BURST_SIZE);
  localparam int TAG_BITS   = PLEN - IDX_BITS - $clog2(BLOCK_SIZE);

  // ----------------------------------------
  // Vector types
  // ----------------------------------------
  typedef logic [XLEN-1:0]         word_t;
  typedef logic [PLEN-1:0]         adr_t;
  typedef logic [XLEN/8-1:0]       be_t;
  typedef logic [IDX_BITS-1:0]     idx_t;
  typedef logic [OFFS_BITS-1:0]    offs_t;
  typedef logic [TAG_BITS-1:0]     ctag_t;
  typedef logic [8*BLOCK_SIZE-1:0] line_t;

  // Bus encodings
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } biu_size_t;

  typedef enum logic {
    TYPE_SINGLE = 1'b0,
    TYPE_INCR4  = 1'b1
  } biu_type_t;

  typedef enum logic [1:0] {
    BIUCMD_NONE,
    BIUCMD_READLINE,
    BIUCMD_WRITEWORD
  } biucmd_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FILL,
    ST_STORE,
    ST_FLUSH,
    ST_ERROR
  } hit_state_t;

endpackage

/* memory/dcache_memory.sv */
module dcache_memory #(
  parameter int WAYS = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             stall_i,
  input  dcache_pkg::idx_t rd_idx_i,
  input  dcache_pkg::adr_t tag_adr_i,
  dcache_mem_if.mem        mif
);
  import dcache_pkg::*;

  logic [WAYS-1:0][SETS-1:0] valid_q;
  ctag_t                     tag_mem [WAYS][SETS];
  line_t                     dat_mem [WAYS][SETS];

  idx_t            idx_q;        // Set held in the tag stage
  ctag_t           core_tag;
  logic [WAYS-1:0] ways_hit;
  logic [6:0]      lfsr;
  logic [WAYS-1:0] fill_way_q;   // One-hot victim

  // ----------------------------------------
  // Lookup
  // ----------------------------------------
  assign core_tag = tag_adr_i[PLEN-1 -: TAG_BITS];

  always_comb begin
    mif.rd_line = '0;
    for (int w = 0; w < WAYS; w++) begin
      ways_hit[w] = valid_q[w][idx_q] && (tag_mem[w][idx_q] == core_tag);
      if (ways_hit[w]) begin
        mif.rd_line = mif.rd_line | dat_mem[w][idx_q];
      end
    end
  end

  assign mif.ways_hit = ways_hit;
  assign mif.hit      = |ways_hit;

  // ----------------------------------------
  // Index and replacement
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q      <= '0;
      lfsr       <= '0;
      fill_way_q <= WAYS'(1);
    end else if (!stall_i) begin          // Frozen during a miss
      idx_q      <= rd_idx_i;
      lfsr       <= {lfsr[5:0], lfsr[6] ~^ lfsr[5]};
      fill_way_q <= WAYS'(1) << (lfsr % WAYS);
    end
  end

  // ----------------------------------------
  // Writes
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (mif.inval) begin
      valid_q <= '0;
    end else if (mif.fill) begin
      for (int w = 0; w < WAYS; w++) begin
        if (fill_way_q[w]) begin
          valid_q[w][mif.wr_idx] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < WAYS; w++) begin
      if (mif.fill && fill_way_q[w]) begin
        tag_mem[w][mif.wr_idx] <= mif.fill_tag;
        dat_mem[w][mif.wr_idx] <= mif.fill_line;
      end else if (mif.we && mif.wr_ways[w]) begin
        for (int b = 0; b < XLEN/8; b++) begin
          if (mif.be[b]) begin
            dat_mem[w][mif.wr_idx][mif.offs*XLEN + b*8 +: 8] <= mif.d[b*8 +: 8];
          end
        end
      end
    end
  end

  // A line is only filled after a miss, so no tag lives in two ways
  a_one_way_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(ways_hit));

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_dcache -o tb_dcache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_dcache)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

/* tests/tb_dcache.sv */
module tb_dcache;
  import dcache_pkg::*;

  localparam int   N_RANDOM       = 500;
  localparam int   TIMEOUT_CYCLES = (N_RANDOM + 125) * 32;   // Worst case about 32 per access
  localparam adr_t LINE_A         = 32'h0000_0120;
  localparam adr_t LINE_C         = 32'h0000_14A0;
  localparam adr_t ERR_ADR        = 32'h0000_1C40;
  localparam adr_t RND_SET        = 32'h0000_0050;            // Set 5, tags 0 to 7

  logic      clk_i;
  logic      rst_ni;
  logic      mem_req_i;
  adr_t      mem_adr_i;
  biu_size_t mem_size_i;
  logic      mem_we_i;
  word_t     mem_d_i;
  logic      stall_o;
  logic      mem_ack_o;
  logic      mem_err_o;
  word_t     mem_q_o;
  logic      cache_flush_i;
  logic      cache_flush_rdy_o;
  logic      biu_stb_o;
  logic      biu_stb_ack_i;
  adr_t      biu_adr_o;
  biu_size_t biu_size_o;
  biu_type_t biu_type_o;
  logic      biu_we_o;
  word_t     biu_d_o;
  word_t     biu_q_i;
  logic      biu_ack_i;
  logic      biu_err_i;

  int          seed = 19635;
  word_t       bus_mem [1024];
  word_t       shadow [1024];
  int unsigned stb_cnt = 0;
  int unsigned burst_cnt = 0;
  int unsigned write_cnt = 0;
  int unsigned ack_cnt = 0;
  int unsigned rdy_cnt = 0;
  int unsigned chk_cnt = 0;
  int unsigned err_cnt = 0;
  int unsigned cycle_cnt = 0;
  int unsigned acc_cycle = 0;
  int unsigned last_latency = 0;

  // Access in flight
  adr_t      cur_adr;
  biu_size_t cur_size;
  logic      exp_we;
  logic      exp_err;
  word_t     exp_q;
  word_t     exp_lanes;     // Store data on its byte lanes
  logic      err_armed = 1'b0;

  dcache_core #(.WAYS(2)) UUT (.*);

  always #10 clk_i = ~clk_i;

  // ----------------------------------------
  // Helpers and reference model
  // ----------------------------------------
  // Tag bits 12:10 and set bits 8:4 keep the lines under test apart
  function automatic int word_index(input adr_t adr);
    return int'({adr[12:10], adr[8:2]});
  endfunction

  function automatic word_t lane_mask(input biu_size_t size, input logic [1:0] off);
    case (size)
      SIZE_BYTE: return word_t'(32'h0000_00FF) << {off, 3'b000};
      SIZE_HALF: return word_t'(32'h0000_FFFF) << {off, 3'b000};
      default:   return '1;
    endcase
  endfunction

  // Expected load value, zero extended
  function automatic word_t ref_load(input adr_t adr, input biu_size_t size);
    word_t w;
    w = shadow[word_index(adr)] >> {adr[1:0], 3'b000};
    return w & lane_mask(size, 2'b00);
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic expect_count(input int unsigned got, input int unsigned want, input string what);
    chk_cnt++;
    assert (got == want)
      else report_error($sformatf("%s is %0d, expected %0d", what, got, want));
  endtask

  task automatic wait_states;
    repeat ($random(seed) & 3) @(negedge clk_i);
  endtask

  // One CPU access, returns after its acknowledge
  task automatic access(input adr_t adr, input biu_size_t size, input logic we, input word_t d);
    int unsigned start;
    word_t       mask;
    start    = ack_cnt;
    cur_adr  = adr;
    cur_size = size;
    exp_we   = we;
    exp_err  = !we && err_armed && (adr[PLEN-1:4] == ERR_ADR[PLEN-1:4]);
    if (we) begin
      exp_lanes = d << {adr[1:0], 3'b000};
      mask      = lane_mask(size, adr[1:0]);
      shadow[word_index(adr)] = (shadow[word_index(adr)] & ~mask) | (exp_lanes & mask);
    end else begin
      exp_q = ref_load(adr, size);
    end
    @(negedge clk_i);
    while (stall_o) @(negedge clk_i);
    mem_req_i  = 1'b1;
    mem_adr_i  = adr;
    mem_size_i = size;
    mem_we_i   = we;
    mem_d_i    = d;
    @(negedge clk_i);
    mem_req_i = 1'b0;
    while (ack_cnt == start) @(negedge clk_i);
  endtask

  task automatic read_miss(input adr_t adr, input biu_size_t size);
    int unsigned b0;
    int unsigned s0;
    b0 = burst_cnt;
    s0 = stb_cnt;
    access(adr, size, 1'b0, '0);
    expect_count(burst_cnt, b0 + 1, "Bursts for a read miss");
    expect_count(stb_cnt, s0 + 1, "Strobes for a read miss");
  endtask

  task automatic read_hit(input adr_t adr, input biu_size_t size);
    int unsigned s0;
    s0 = stb_cnt;
    access(adr, size, 1'b0, '0);
    expect_count(stb_cnt, s0, "Strobes for a read hit");
    expect_count(last_latency, 2, "Read hit latency");
  endtask

  task automatic store(input adr_t adr, input biu_size_t size, input word_t d);
    int unsigned b0;
    int unsigned w0;
    b0 = burst_cnt;
    w0 = write_cnt;
    access(adr, size, 1'b1, d);
    expect_count(write_cnt, w0 + 1, "Bus writes for a store");
    expect_count(burst_cnt, b0, "Bursts for a store");
  endtask

  task automatic flush_cache;
    int unsigned start;
    start = rdy_cnt;
    @(negedge clk_i);
    while (stall_o) @(negedge clk_i);
    cache_flush_i = 1'b1;
    @(negedge clk_i);
    cache_flush_i = 1'b0;
    while (rdy_cnt == start) @(negedge clk_i);
  endtask

  // ----------------------------------------
  // Bus memory model
  // ----------------------------------------
  task automatic serve_bus;
    adr_t  adr;
    logic  burst;
    word_t mask;
    adr   = biu_adr_o;
    burst = (biu_type_o == TYPE_INCR4);
    mask  = lane_mask(cur_size, cur_adr[1:0]);
    stb_cnt++;
    chk_cnt++;
    assert (stall_o)
      else report_error("stall_o is low while a bus transfer is pending");
    chk_cnt++;
    if (burst) begin
      burst_cnt++;
      assert (!biu_we_o && biu_size_o == SIZE_WORD && adr == {cur_adr[PLEN-1:4], 4'h0})
        else report_error($sformatf("burst at %h for load at %h", adr, cur_adr));
    end else begin
      write_cnt++;
      assert (biu_we_o && biu_size_o == cur_size && adr == cur_adr &&
              (biu_d_o & mask) == (exp_lanes & mask))
        else report_error($sformatf("bus write %h data %h, expected %h data %h",
                                    adr, biu_d_o, cur_adr, exp_lanes));
    end
    wait_states();
    if (burst && err_armed && adr[PLEN-1:4] == ERR_ADR[PLEN-1:4]) begin
      biu_err_i = 1'b1;                   // Error in the address phase
      @(negedge clk_i);
      biu_err_i = 1'b0;
    end else begin
      biu_stb_ack_i = 1'b1;
      @(negedge clk_i);
      biu_stb_ack_i = 1'b0;
      for (int i = 0; i < (burst ? BURST_SIZE : 1); i++) begin
        wait_states();
        biu_ack_i = 1'b1;
        if (burst) begin
          biu_q_i = bus_mem[word_index(adr + adr_t'(4 * i))];
        end else begin
          bus_mem[word_index(adr)] = (bus_mem[word_index(adr)] & ~mask) | (biu_d_o & mask);
        end
        @(negedge clk_i);
        biu_ack_i = 1'b0;
      end
    end
  endtask

  initial begin : bus_model
    biu_stb_ack_i = 1'b0;
    biu_q_i       = '0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && biu_stb_o) serve_bus();
    end
  end

  // ----------------------------------------
  // Response checker and watchdog
  // ----------------------------------------
  always @(posedge clk_i) begin : check_responses
    if (rst_ni) begin
      if (mem_req_i && !stall_o) acc_cycle = cycle_cnt;
      if (cache_flush_rdy_o) rdy_cnt++;
      if (mem_ack_o) begin
        ack_cnt++;
        last_latency = cycle_cnt - acc_cycle;
        chk_cnt++;
        assert (mem_err_o == exp_err)
          else report_error($sformatf("access %h err %b, expected %b", cur_adr, mem_err_o, exp_err));
        if (!exp_we && !exp_err) begin
          chk_cnt++;
          assert (mem_q_o == exp_q)
            else report_error($sformatf("load %h got %h, expected %h", cur_adr, mem_q_o, exp_q));
        end
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : stimulus
    adr_t        adr;
    biu_size_t   size;
    logic        we;
    int unsigned b0;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    mem_req_i     = 1'b0;
    mem_adr_i     = '0;
    mem_size_i    = SIZE_WORD;
    mem_we_i      = 1'b0;
    mem_d_i       = '0;
    cache_flush_i = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      bus_mem[i] = $random(seed);
      shadow[i]  = bus_mem[i];
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Miss, then hits in the filled line
    read_miss(LINE_A + 4, SIZE_WORD);
    read_hit(LINE_A + 9, SIZE_BYTE);
    read_hit(LINE_A + 14, SIZE_HALF);
    read_hit(LINE_A, SIZE_WORD);

    // Stores to a cached line and to a line that is not cached
    store(LINE_A + 5, SIZE_BYTE, 32'h0000_00A5);
    store(LINE_A + 10, SIZE_HALF, 32'h0000_BEEF);
    store(LINE_A, SIZE_WORD, 32'h1234_5678);
    read_hit(LINE_A + 4, SIZE_WORD);
    read_hit(LINE_A + 8, SIZE_WORD);
    read_hit(LINE_A, SIZE_WORD);
    store(LINE_C + 3, SIZE_BYTE, 32'h0000_003C);
    store(LINE_C + 6, SIZE_HALF, 32'h0000_C0DE);
    store(LINE_C + 12, SIZE_WORD, 32'hCAFE_F00D);
    read_miss(LINE_C, SIZE_WORD);
    read_hit(LINE_C + 4, SIZE_WORD);
    read_hit(LINE_C + 12, SIZE_WORD);

    // Flush drops every line
    flush_cache();
    read_miss(LINE_A + 8, SIZE_WORD);

    // Bus error on a fill, line stays invalid
    err_armed = 1'b1;
    read_miss(ERR_ADR + 4, SIZE_WORD);
    read_miss(ERR_ADR + 4, SIZE_WORD);
    err_armed = 1'b0;
    read_miss(ERR_ADR + 4, SIZE_WORD);
    read_hit(ERR_ADR, SIZE_WORD);

    // Random mix over 8 lines of one set
    b0 = burst_cnt;
    for (int i = 0; i < N_RANDOM; i++) begin
      adr = RND_SET + adr_t'(($random(seed) & 7) << 10) + adr_t'(($random(seed) & 3) << 2);
      case ($random(seed) & 3)
        0: begin
          size = SIZE_BYTE;
          adr  = adr + adr_t'($random(seed) & 3);
        end
        1: begin
          size = SIZE_HALF;
          adr  = adr + adr_t'(($random(seed) & 1) << 1);
        end
        default: size = SIZE_WORD;
      endcase
      we = ($random(seed) & 1) == 1;
      access(adr, size, we, $random(seed));
    end
    chk_cnt++;
    assert (burst_cnt > b0 + 8)
      else report_error("random phase caused too few refills");

    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog/dcache_biu_ctrl.sv */
module dcache_biu_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  dcache_biucmd_if.biu          cmd_if,
  output logic                  biu_stb_o,
  input  logic                  biu_stb_ack_i,
  output dcache_pkg::adr_t      biu_adr_o,
  output dcache_pkg::biu_size_t biu_size_o,
  output dcache_pkg::biu_type_t biu_type_o,
  output logic                  biu_we_o,
  output dcache_pkg::word_t     biu_d_o,
  input  dcache_pkg::word_t     biu_q_i,
  input  logic                  biu_ack_i,
  input  logic                  biu_err_i
);
  import dcache_pkg::*;

  typedef enum logic [1:0] {
    B_IDLE,
    B_REQ,
    B_DATA,
    B_DONE
  } biu_state_t;

  biu_state_t state_q;
  offs_t      beat_q;
  logic       err_q;
  line_t      line_q;
  logic       last_beat;
  biu_size_t  wr_size;

  assign biu_stb_o   = (state_q == B_REQ);
  assign cmd_if.busy = (state_q != B_IDLE);
  assign cmd_if.ack  = (state_q == B_DONE);
  assign cmd_if.err  = err_q;
  assign cmd_if.line = line_q;

  assign last_beat = (biu_type_o == TYPE_SINGLE) || (beat_q == offs_t'(BURST_SIZE-1));

  always_comb begin
    case (cmd_if.be)
      4'b1111:          wr_size = SIZE_WORD;
      4'b0011, 4'b1100: wr_size = SIZE_HALF;
      default:          wr_size = SIZE_BYTE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= B_IDLE;
      beat_q  <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        B_IDLE: begin
          if (cmd_if.cmd != BIUCMD_NONE) begin
            state_q <= B_REQ;
            beat_q  <= '0;
            err_q   <= 1'b0;
          end
        end
        B_REQ: begin
          if (biu_err_i) begin
            err_q   <= 1'b1;
            state_q <= B_DONE;
          end else if (biu_stb_ack_i) begin
            state_q <= B_DATA;
          end
        end
        B_DATA: begin
          if (biu_err_i) begin
            err_q   <= 1'b1;
            state_q <= B_DONE;
          end else if (biu_ack_i) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) state_q <= B_DONE;
          end
        end
        default: state_q <= B_IDLE;          // Ack pulse sent
      endcase
    end
  end

  // Transfer attributes held for the whole access
  always_ff @(posedge clk_i) begin
    if (state_q == B_IDLE && cmd_if.cmd != BIUCMD_NONE) begin
      biu_adr_o  <= cmd_if.adr;
      biu_we_o   <= (cmd_if.cmd == BIUCMD_WRITEWORD);
      biu_d_o    <= cmd_if.d;
      biu_type_o <= (cmd_if.cmd == BIUCMD_READLINE) ? TYPE_INCR4 : TYPE_SINGLE;
      biu_size_o <= (cmd_if.cmd == BIUCMD_READLINE) ? SIZE_WORD : wr_size;
    end
    if (state_q == B_DATA && biu_ack_i) begin
      line_q[beat_q*XLEN +: XLEN] <= biu_q_i;
    end
  end

endmodule

/* verilog/dcache_core.sv */
module dcache_core #(
  parameter int WAYS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // CPU side
  input  logic                  mem_req_i,
  input  dcache_pkg::adr_t      mem_adr_i,
  input  dcache_pkg::biu_size_t mem_size_i,
  input  logic                  mem_we_i,
  input  dcache_pkg::word_t     mem_d_i,
  output logic                  stall_o,
  output logic                  mem_ack_o,
  output logic                  mem_err_o,
  output dcache_pkg::word_t     mem_q_o,
  input  logic                  cache_flush_i,
  output logic                  cache_flush_rdy_o,

  // Bus side
  output logic                  biu_stb_o,
  input  logic                  biu_stb_ack_i,
  output dcache_pkg::adr_t      biu_adr_o,
  output dcache_pkg::biu_size_t biu_size_o,
  output dcache_pkg::biu_type_t biu_type_o,
  output logic                  biu_we_o,
  output dcache_pkg::word_t     biu_d_o,
  input  dcache_pkg::word_t     biu_q_i,
  input  logic                  biu_ack_i,
  input  logic                  biu_err_i
);
  import dcache_pkg::*;

  idx_t      rd_idx;
  logic      tag_req;
  adr_t      tag_adr;
  logic      tag_we;
  be_t       tag_be;
  biu_size_t tag_size;
  word_t     tag_d;
  logic      tag_flush;

  dcache_mem_if #(.WAYS(WAYS)) mem_if ();
  dcache_biucmd_if             biucmd_if ();

  // ----------------------------------------
  // Setup and tag stages
  // ----------------------------------------
  dcache_req_pipe u_req_pipe (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_i      (stall_o),
    .req_i        (mem_req_i),
    .adr_i        (mem_adr_i),
    .size_i       (mem_size_i),
    .we_i         (mem_we_i),
    .d_i          (mem_d_i),
    .cacheflush_i (cache_flush_i),
    .rd_idx_o     (rd_idx),
    .tag_req_o    (tag_req),
    .tag_adr_o    (tag_adr),
    .tag_we_o     (tag_we),
    .tag_be_o     (tag_be),
    .tag_size_o   (tag_size),
    .tag_d_o      (tag_d),
    .tag_flush_o  (tag_flush)
  );

  dcache_memory #(.WAYS(WAYS)) u_memory (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .stall_i   (stall_o),
    .rd_idx_i  (rd_idx),
    .tag_adr_i (tag_adr),
    .mif       (mem_if.mem)
  );

  // ----------------------------------------
  // Control
  // ----------------------------------------
  dcache_hit_ctrl #(.WAYS(WAYS)) u_hit_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tag_req_i   (tag_req),
    .tag_adr_i   (tag_adr),
    .tag_we_i    (tag_we),
    .tag_be_i    (tag_be),
    .tag_size_i  (tag_size),
    .tag_d_i     (tag_d),
    .tag_flush_i (tag_flush),
    .stall_o     (stall_o),
    .ack_o       (mem_ack_o),
    .err_o       (mem_err_o),
    .q_o         (mem_q_o),
    .flush_rdy_o (cache_flush_rdy_o),
    .mif         (mem_if.ctrl),
    .biu         (biucmd_if.hit)
  );

  dcache_biu_ctrl u_biu_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_if        (biucmd_if.biu),
    .biu_stb_o     (biu_stb_o),
    .biu_stb_ack_i (biu_stb_ack_i),
    .biu_adr_o     (biu_adr_o),
    .biu_size_o    (biu_size_o),
    .biu_type_o    (biu_type_o),
    .biu_we_o      (biu_we_o),
    .biu_d_o       (biu_d_o),
    .biu_q_i       (biu_q_i),
    .biu_ack_i     (biu_ack_i),
    .biu_err_i     (biu_err_i)
  );

endmodule

/* verilog/dcache_hit_ctrl.sv */
module dcache_hit_ctrl #(
  parameter int WAYS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  tag_req_i,
  input  dcache_pkg::adr_t      tag_adr_i,
  input  logic                  tag_we_i,
  input  dcache_pkg::be_t       tag_be_i,
  input  dcache_pkg::biu_size_t tag_size_i,
  input  dcache_pkg::word_t     tag_d_i,
  input  logic                  tag_flush_i,
  output logic                  stall_o,
  output logic                  ack_o,
  output logic                  err_o,
  output dcache_pkg::word_t     q_o,
  output logic                  flush_rdy_o,
  dcache_mem_if.ctrl            mif,
  dcache_biucmd_if.hit          biu
);
  import dcache_pkg::*;

  hit_state_t      state_q;
  hit_state_t      state_d;
  logic [WAYS-1:0] store_ways_q;
  logic            rd_req;
  logic            st_req;
  offs_t           offs;
  word_t           rd_word;
  word_t           shifted;

  assign rd_req = tag_req_i & ~tag_we_i & ~tag_flush_i;
  assign st_req = tag_req_i &  tag_we_i & ~tag_flush_i;
  assign offs   = tag_adr_i[PLEN-TAG_BITS-IDX_BITS-1 -: OFFS_BITS];

  // Load data shifted down and zero extended
  assign rd_word = mif.rd_line[offs*XLEN +: XLEN];
  assign shifted = rd_word >> {tag_adr_i[1:0], 3'b000};

  always_comb begin
    case (tag_size_i)
      SIZE_BYTE: q_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
      SIZE_HALF: q_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
      default:   q_o = shifted;
    endcase
  end

  // ----------------------------------------
  // Memory and bus command fields
  // ----------------------------------------
  assign mif.wr_idx    = tag_adr_i[PLEN-TAG_BITS-1 -: IDX_BITS];
  assign mif.offs      = offs;
  assign mif.d         = tag_d_i;
  assign mif.be        = tag_be_i;
  assign mif.wr_ways   = store_ways_q;
  assign mif.fill_line = biu.line;
  assign mif.fill_tag  = tag_adr_i[PLEN-1 -: TAG_BITS];

  assign biu.adr = tag_we_i ? tag_adr_i : tag_adr_i & ~adr_t'(BLOCK_SIZE-1);
  assign biu.d   = tag_d_i;
  assign biu.be  = tag_be_i;

  always_comb begin
    state_d     = state_q;
    stall_o     = 1'b0;
    ack_o       = 1'b0;
    err_o       = 1'b0;
    flush_rdy_o = 1'b0;
    biu.cmd     = BIUCMD_NONE;
    mif.we      = 1'b0;
    mif.fill    = 1'b0;
    mif.inval   = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (tag_flush_i) begin
          stall_o = 1'b1;
          state_d = ST_FLUSH;
        end else if (st_req) begin
          stall_o = 1'b1;
          if (!biu.busy) state_d = ST_STORE;
        end else if (rd_req) begin
          if (mif.hit) begin
            ack_o = 1'b1;                     // Hit answered from the line
          end else begin
            stall_o = 1'b1;
            if (!biu.busy) state_d = ST_FILL;
          end
        end
      end
      ST_FILL: begin
        stall_o = 1'b1;
        biu.cmd = BIUCMD_READLINE;
        if (biu.ack) begin
          mif.fill = ~biu.err;
          state_d  = biu.err ? ST_ERROR : ST_IDLE;   // Refilled line then hits
        end
      end
      ST_STORE: begin
        stall_o = ~biu.ack;
        biu.cmd = BIUCMD_WRITEWORD;
        if (biu.ack) begin
          mif.we  = ~biu.err;
          ack_o   = 1'b1;
          err_o   = biu.err;
          state_d = ST_IDLE;
        end
      end
      ST_FLUSH: begin
        mif.inval   = 1'b1;
        flush_rdy_o = 1'b1;
        state_d     = ST_IDLE;
      end
      ST_ERROR: begin
        ack_o   = 1'b1;
        err_o   = 1'b1;
        state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= ST_IDLE;
    else         state_q <= state_d;
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE) store_ways_q <= mif.ways_hit;
  end

  a_stall_on_cmd : assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu.busy && !biu.ack |-> stall_o);

endmodule

/* verilog/dcache_req_pipe.sv */
module dcache_req_pipe (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  stall_i,
  input  logic                  req_i,
  input  dcache_pkg::adr_t      adr_i,
  input  dcache_pkg::biu_size_t size_i,
  input  logic                  we_i,
  input  dcache_pkg::word_t     d_i,
  input  logic                  cacheflush_i,
  output dcache_pkg::idx_t      rd_idx_o,
  output logic                  tag_req_o,
  output dcache_pkg::adr_t      tag_adr_o,
  output logic                  tag_we_o,
  output dcache_pkg::be_t       tag_be_o,
  output dcache_pkg::biu_size_t tag_size_o,
  output dcache_pkg::word_t     tag_d_o,
  output logic                  tag_flush_o
);
  import dcache_pkg::*;

  logic      setup_req;
  logic      setup_flush;
  adr_t      setup_adr;
  biu_size_t setup_size;
  logic      setup_we;
  word_t     setup_d;
  be_t       setup_be;

  // Set index of the request about to enter the tag stage
  assign rd_idx_o = setup_adr[PLEN-TAG_BITS-1 -: IDX_BITS];

  always_comb begin
    case (setup_size)
      SIZE_BYTE: setup_be = be_t'(4'b0001) << setup_adr[1:0];
      SIZE_HALF: setup_be = be_t'(4'b0011) << setup_adr[1:0];
      default:   setup_be = '1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      setup_req   <= 1'b0;
      setup_flush <= 1'b0;
      tag_req_o   <= 1'b0;
      tag_flush_o <= 1'b0;
    end else if (!stall_i) begin
      setup_req   <= req_i;
      setup_flush <= cacheflush_i;
      tag_req_o   <= setup_req;
      tag_flush_o <= setup_flush;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      setup_adr  <= adr_i;
      setup_size <= size_i;
      setup_we   <= we_i;
      setup_d    <= d_i;
      tag_adr_o  <= setup_adr;
      tag_size_o <= setup_size;
      tag_we_o   <= setup_we;
      tag_be_o   <= setup_be;
      tag_d_o    <= setup_d << {setup_adr[1:0], 3'b000};   // Onto byte lanes
    end
  end

  a_word_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !stall_i && size_i == SIZE_WORD |-> adr_i[1:0] == 2'b00);

endmodule
